// File: rv_core_settings.svh
// Build-time sizes and boot vectors for the RV32I core
// Include wherever widths or vector addresses are needed
`ifndef RV_CORE_SETTINGS_SVH
`define RV_CORE_SETTINGS_SVH

// Register and datapath width
`define RV_XLEN 32

// Byte address width of the shared memory port
`define RV_AWIDTH 16

// Boot vectors, read once after reset
`define RV_VEC_RESET 16'h0000
`define RV_VEC_SP 16'h0004

// Architectural register count
`define RV_NREGS 32

`endif

// File: rv_isa_pkg.sv
// RV32I instruction set encodings and instruction word formats
// Shared by the decoder, the LSU and the core
`default_nettype none

package rv_isa_pkg;

   typedef enum logic [6:0] {
      OP_LOAD   = 7'b0000011,
      OP_ALU_I  = 7'b0010011,
      OP_AUIPC  = 7'b0010111,
      OP_STORE  = 7'b0100011,
      OP_ALU_R  = 7'b0110011,
      OP_LUI    = 7'b0110111,
      OP_BRANCH = 7'b1100011,
      OP_JALR   = 7'b1100111,
      OP_JAL    = 7'b1101111
   } opcode_e;

   typedef enum logic [2:0] {
      BR_BEQ  = 3'h0,
      BR_BNE  = 3'h1,
      BR_BLT  = 3'h4,
      BR_BGE  = 3'h5,
      BR_BLTU = 3'h6,
      BR_BGEU = 3'h7
   } branch_e;

   // Load and store access sizes, U forms zero-extend
   typedef enum logic [2:0] {
      SZ_B  = 3'h0,
      SZ_H  = 3'h1,
      SZ_W  = 3'h2,
      SZ_BU = 3'h4,
      SZ_HU = 3'h5
   } size_e;

   typedef struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
   } r_fmt_t;

   typedef struct packed {
      logic [11:0] imm;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
   } i_fmt_t;

   typedef struct packed {
      logic [6:0] imm_hi;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] imm_lo;
      logic [6:0] opcode;
   } s_fmt_t;

   // Branch offset bits are scattered around the register fields
   typedef struct packed {
      logic       imm12;
      logic [5:0] imm10_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [3:0] imm4_1;
      logic       imm11;
      logic [6:0] opcode;
   } b_fmt_t;

   typedef struct packed {
      logic [19:0] imm;
      logic [4:0]  rd;
      logic [6:0]  opcode;
   } u_fmt_t;

   typedef struct packed {
      logic       imm20;
      logic [9:0] imm10_1;
      logic       imm11;
      logic [7:0] imm19_12;
      logic [4:0] rd;
      logic [6:0] opcode;
   } j_fmt_t;

   // One fetched word, viewed through each format
   typedef union packed {
      r_fmt_t r;
      i_fmt_t i;
      s_fmt_t s;
      b_fmt_t b;
      u_fmt_t u;
      j_fmt_t j;
   } insn_u;

endpackage

`default_nettype wire

// File: rv_core_pkg.sv
// Core-internal types for the multi-cycle RV32I core
// FSM states, ALU functions, decoded fields and the memory write bundle
`default_nettype none

`include "rv_core_settings.svh"

package rv_core_pkg;

   typedef enum logic [4:0] {
      ST_BOOT,
      ST_BOOT_SP,
      ST_WR_SP,
      ST_BOOT_PC,
      ST_FETCH,
      ST_DECODE,
      ST_REG,
      ST_X_ALU,
      ST_X_JAL,
      ST_X_JALR,
      ST_X_BRANCH,
      ST_X_STORE,
      ST_X_LOAD,
      ST_FAULT
   } state_e;

   // funct7 bit 5 followed by funct3
   typedef enum logic [3:0] {
      ALU_ADD  = 4'b0000,
      ALU_SLL  = 4'b0001,
      ALU_SLT  = 4'b0010,
      ALU_SLTU = 4'b0011,
      ALU_XOR  = 4'b0100,
      ALU_SRL  = 4'b0101,
      ALU_OR   = 4'b0110,
      ALU_AND  = 4'b0111,
      ALU_SUB  = 4'b1000,
      ALU_SRA  = 4'b1101
   } alu_fn_e;

   typedef struct packed {
      rv_isa_pkg::opcode_e opcode;
      logic [4:0]          rd;
      logic [4:0]          rs1;
      logic [4:0]          rs2;
      logic [2:0]          funct3;
      logic                f7b5;
      logic [31:0]         imm;
   } decoded_t;

   typedef struct packed {
      logic [`RV_AWIDTH-1:0] addr;
      logic [`RV_XLEN-1:0]   data;
      logic [3:0]            mask;
   } mem_wr_t;

endpackage

`default_nettype wire

// File: rv_decoder.sv
// Combinational instruction decoder
// Splits a fetched word into register fields and a sign-extended immediate
`timescale 1ns/1ps
`default_nettype none

module rv_decoder (
   input  rv_isa_pkg::insn_u     insn,
   output rv_core_pkg::decoded_t dec
);

   import rv_isa_pkg::*;

   always_comb begin
      dec.opcode = opcode_e'(insn.r.opcode);
      dec.rd     = insn.r.rd;
      dec.rs1    = insn.r.rs1;
      dec.rs2    = insn.r.rs2;
      dec.funct3 = insn.r.funct3;
      // Also bit 10 of the I immediate, which picks SRAI over SRLI
      dec.f7b5   = insn.r.funct7[5];

      case (insn.r.opcode)
         OP_ALU_I,
         OP_LOAD,
         OP_JALR: begin
            dec.imm = {{20{insn.i.imm[11]}}, insn.i.imm};
         end
         OP_STORE: begin
            dec.imm = {{20{insn.s.imm_hi[6]}}, insn.s.imm_hi, insn.s.imm_lo};
         end
         OP_BRANCH: begin
            dec.imm = {{19{insn.b.imm12}}, insn.b.imm12, insn.b.imm11,
                       insn.b.imm10_5, insn.b.imm4_1, 1'b0};
         end
         OP_LUI,
         OP_AUIPC: begin
            dec.imm = {insn.u.imm, 12'b0};
         end
         OP_JAL: begin
            dec.imm = {{11{insn.j.imm20}}, insn.j.imm20, insn.j.imm19_12,
                       insn.j.imm11, insn.j.imm10_1, 1'b0};
         end
         default: begin
            dec.imm = '0;
         end
      endcase
   end

endmodule

`default_nettype wire

// File: rv_alu.sv
// Combinational ALU for the RV32I core
// Compare functions return 0 or 1 in bit 0
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_settings.svh"

module rv_alu (
   input  logic [`RV_XLEN-1:0] x,
   input  logic [`RV_XLEN-1:0] y,
   input  rv_core_pkg::alu_fn_e fn,
   output logic [`RV_XLEN-1:0] result,
   output logic                zero
);

   import rv_core_pkg::*;

   logic [4:0] shamt;

   assign shamt = y[4:0];

   always_comb begin
      case (fn)
         ALU_ADD:  result = x + y;
         ALU_SUB:  result = x - y;
         ALU_SLL:  result = x << shamt;
         ALU_SRL:  result = x >> shamt;
         ALU_SRA:  result = $signed(x) >>> shamt;
         ALU_SLT:  result = {{(`RV_XLEN-1){1'b0}}, $signed(x) < $signed(y)};
         ALU_SLTU: result = {{(`RV_XLEN-1){1'b0}}, x < y};
         ALU_XOR:  result = x ^ y;
         ALU_OR:   result = x | y;
         ALU_AND:  result = x & y;
         default:  result = '0;
      endcase
   end

   // BEQ and BNE look at this after a subtract
   assign zero = (result == '0);

endmodule

`default_nettype wire

// File: rv_regfile.sv
// Integer register file, two registered read ports and one write port
// x0 is cleared on reset and never written
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_settings.svh"

module rv_regfile (
   input  logic                clk,
   input  logic                rst,
   input  logic [4:0]          rs1,
   input  logic [4:0]          rs2,
   output logic [`RV_XLEN-1:0] rs1_val,
   output logic [`RV_XLEN-1:0] rs2_val,
   input  logic                reg_wen,
   input  logic [4:0]          rd,
   input  logic [`RV_XLEN-1:0] rd_val
);

   logic [`RV_XLEN-1:0] regs [`RV_NREGS];

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int n = 0; n < `RV_NREGS; n++) begin
            regs[n] <= '0;
         end
         rs1_val <= '0;
         rs2_val <= '0;
      end else begin
         if (reg_wen && rd != 5'd0) begin
            regs[rd] <= rd_val;
         end
         // Same-edge write is not forwarded
         rs1_val <= regs[rs1];
         rs2_val <= regs[rs2];
      end
   end

endmodule

`default_nettype wire

// File: rv_lsu.sv
// Load/store alignment unit
// Places store data on its byte lanes and extracts and extends load data
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_settings.svh"

module rv_lsu (
   input  logic [`RV_XLEN-1:0] addr,
   input  logic [`RV_XLEN-1:0] store_val,
   input  rv_isa_pkg::size_e   size,
   input  logic [`RV_XLEN-1:0] rdata,
   output rv_core_pkg::mem_wr_t wr,
   output logic [`RV_XLEN-1:0] load_val
);

   import rv_isa_pkg::*;

   logic [1:0]          ofs;
   logic [3:0]          base_mask;
   logic [`RV_XLEN-1:0] shifted;

   assign ofs = addr[1:0];

   // Lane i holds byte offset i
   always_comb begin
      case (size)
         SZ_B, SZ_BU: base_mask = 4'b0001;
         SZ_H, SZ_HU: base_mask = 4'b0011;
         default:     base_mask = 4'b1111;
      endcase
   end

   always_comb begin
      wr.addr = addr[`RV_AWIDTH-1:0];
      wr.data = store_val << {ofs, 3'b000};
      wr.mask = base_mask << ofs;
   end

   assign shifted = rdata >> {ofs, 3'b000};

   always_comb begin
      case (size)
         SZ_B:    load_val = {{24{shifted[7]}}, shifted[7:0]};
         SZ_H:    load_val = {{16{shifted[15]}}, shifted[15:0]};
         SZ_BU:   load_val = {24'b0, shifted[7:0]};
         SZ_HU:   load_val = {16'b0, shifted[15:0]};
         default: load_val = shifted;
      endcase
   end

endmodule

`default_nettype wire

// File: rv_core.sv
// Multi-cycle RV32I core with one shared memory port
// Boots from the SP and reset vectors, then runs one instruction at a time
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_settings.svh"

module rv_core (
   input  logic                  clk,
   input  logic                  rst,
   output logic                  ren,
   output logic [`RV_AWIDTH-1:0] addr,
   input  logic [31:0]           rdata,
   input  logic                  rd_valid,
   output logic                  wen,
   output rv_core_pkg::mem_wr_t  wr,
   output logic                  fault
);

   import rv_isa_pkg::*;
   import rv_core_pkg::*;

   state_e                state;
   logic [`RV_AWIDTH-1:0] pc;
   logic [`RV_AWIDTH-1:0] pc_plus_4;
   logic [`RV_AWIDTH-1:0] pc_plus_imm;
   logic [`RV_XLEN-1:0]   word_q;
   decoded_t              dec;
   decoded_t              dec_q;

   logic [`RV_XLEN-1:0]   rs1_val;
   logic [`RV_XLEN-1:0]   rs2_val;
   logic                  reg_wen;
   logic [4:0]            rd_idx;
   logic [`RV_XLEN-1:0]   rd_val;

   logic [`RV_XLEN-1:0]   alu_x;
   logic [`RV_XLEN-1:0]   alu_y;
   alu_fn_e               alu_fn;
   logic [`RV_XLEN-1:0]   alu_result;
   logic                  alu_zero;
   logic [`RV_XLEN-1:0]   load_val;
   logic                  taken;

   rv_decoder i_decoder (.insn(word_q), .dec(dec));

   rv_regfile i_regfile (
      .clk(clk), .rst(rst),
      .rs1(dec_q.rs1), .rs2(dec_q.rs2), .rs1_val(rs1_val), .rs2_val(rs2_val),
      .reg_wen(reg_wen), .rd(rd_idx), .rd_val(rd_val)
   );

   rv_alu i_alu (.x(alu_x), .y(alu_y), .fn(alu_fn), .result(alu_result), .zero(alu_zero));

   rv_lsu i_lsu (
      .addr(alu_result), .store_val(rs2_val), .size(size_e'(dec_q.funct3)),
      .rdata(rdata), .wr(wr), .load_val(load_val)
   );

   assign pc_plus_4   = pc + `RV_AWIDTH'(4);
   assign pc_plus_imm = pc + dec_q.imm[`RV_AWIDTH-1:0];

   // Operand and function select, by opcode
   always_comb begin
      alu_x  = rs1_val;
      alu_y  = dec_q.imm;
      alu_fn = ALU_ADD;
      case (dec_q.opcode)
         OP_ALU_R: begin
            alu_y  = rs2_val;
            alu_fn = alu_fn_e'({dec_q.f7b5, dec_q.funct3});
         end
         OP_ALU_I: begin
            alu_fn = alu_fn_e'({(dec_q.funct3 == 3'h1 || dec_q.funct3 == 3'h5) && dec_q.f7b5,
                                dec_q.funct3});
         end
         OP_BRANCH: begin
            alu_y = rs2_val;
            case (branch_e'(dec_q.funct3))
               BR_BEQ, BR_BNE: alu_fn = ALU_SUB;
               BR_BLT, BR_BGE: alu_fn = ALU_SLT;
               default:        alu_fn = ALU_SLTU;
            endcase
         end
         OP_LUI:   alu_x = '0;
         OP_AUIPC: alu_x = {{(`RV_XLEN-`RV_AWIDTH){1'b0}}, pc};
         default: ;
      endcase
   end

   always_comb begin
      case (branch_e'(dec_q.funct3))
         BR_BEQ:          taken = alu_zero;
         BR_BNE:          taken = !alu_zero;
         BR_BLT, BR_BLTU: taken = alu_result[0];
         BR_BGE, BR_BGEU: taken = !alu_result[0];
         default:         taken = 1'b0;
      endcase
   end

   // Memory read side and register writeback
   always_comb begin
      ren     = 1'b0;
      addr    = '0;
      reg_wen = 1'b0;
      rd_idx  = dec_q.rd;
      rd_val  = alu_result;
      case (state)
         ST_BOOT_SP: begin
            ren  = 1'b1;
            addr = `RV_VEC_SP;
         end
         ST_WR_SP: begin
            reg_wen = 1'b1;
            rd_idx  = 5'd2;
            rd_val  = word_q;
         end
         ST_BOOT_PC: begin
            ren  = 1'b1;
            addr = `RV_VEC_RESET;
         end
         ST_FETCH: begin
            ren  = 1'b1;
            addr = pc;
         end
         ST_X_ALU: reg_wen = 1'b1;
         ST_X_JAL, ST_X_JALR: begin
            reg_wen = 1'b1;
            rd_val  = {{(`RV_XLEN-`RV_AWIDTH){1'b0}}, pc_plus_4};
         end
         ST_X_LOAD: begin
            ren     = 1'b1;
            addr    = alu_result[`RV_AWIDTH-1:0];
            reg_wen = rd_valid;
            rd_val  = load_val;
         end
         default: ;
      endcase
   end

   assign wen   = (state == ST_X_STORE) && (wr.addr != '0);
   assign fault = (state == ST_FAULT);

   always_ff @(posedge clk) begin
      if ((state == ST_BOOT_SP || state == ST_FETCH) && rd_valid) begin
         word_q <= rdata;
      end
      if (state == ST_DECODE) begin
         dec_q <= dec;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= ST_BOOT;
         pc    <= '0;
      end else begin
         case (state)
            ST_BOOT:    state <= ST_BOOT_SP;
            ST_BOOT_SP: if (rd_valid) state <= ST_WR_SP;
            ST_WR_SP:   state <= ST_BOOT_PC;
            ST_BOOT_PC: begin
               if (rd_valid) begin
                  pc    <= rdata[`RV_AWIDTH-1:0];
                  state <= ST_FETCH;
               end
            end
            ST_FETCH:   if (rd_valid) state <= ST_DECODE;
            ST_DECODE: begin
               case (dec.opcode)
                  OP_ALU_R, OP_ALU_I, OP_LOAD, OP_STORE, OP_BRANCH, OP_JALR: state <= ST_REG;
                  OP_LUI, OP_AUIPC: state <= ST_X_ALU;
                  OP_JAL:           state <= ST_X_JAL;
                  default:          state <= ST_FAULT;
               endcase
            end
            ST_REG: begin
               case (dec_q.opcode)
                  OP_LOAD:   state <= ST_X_LOAD;
                  OP_STORE:  state <= ST_X_STORE;
                  OP_BRANCH: state <= ST_X_BRANCH;
                  OP_JALR:   state <= ST_X_JALR;
                  default:   state <= ST_X_ALU;
               endcase
            end
            ST_X_ALU, ST_X_STORE: begin
               pc    <= pc_plus_4;
               state <= ST_FETCH;
            end
            ST_X_LOAD: begin
               if (rd_valid) begin
                  pc    <= pc_plus_4;
                  state <= ST_FETCH;
               end
            end
            ST_X_JAL: begin
               pc    <= pc_plus_imm;
               state <= ST_FETCH;
            end
            ST_X_JALR: begin
               pc    <= {alu_result[`RV_AWIDTH-1:1], 1'b0};
               state <= ST_FETCH;
            end
            ST_X_BRANCH: begin
               pc    <= taken ? pc_plus_imm : pc_plus_4;
               state <= ST_FETCH;
            end
            // Fault holds until reset
            default: state <= ST_FAULT;
         endcase
      end
   end

endmodule

`default_nettype wire

// File: tb_rv_core.sv
// Testbench for the multi-cycle RV32I core
// Runs a table of small programs against a memory model and checks the final store
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_settings.svh"

module tb_rv_core;

   import rv_isa_pkg::*;
   import rv_core_pkg::*;

   localparam int MAX_TESTS  = 48;
   localparam int TIMEOUT    = 2000;
   localparam int FAULT_HOLD = 8;
   localparam int PROG_BASE  = 32'h100;
   localparam int STACK_TOP  = 32'h200;

   logic                  clk      = 1'b0;
   logic                  rst      = 1'b1;
   logic [31:0]           rdata    = '0;
   logic                  rd_valid = 1'b0;
   logic                  ren;
   logic [`RV_AWIDTH-1:0] addr;
   logic                  wen;
   mem_wr_t               wr;
   logic                  fault;

   // 1 KB memory model
   logic [31:0] mem [256];
   integer      seed  = 38;
   int          rnd;
   logic [1:0]  delay = 2'd0;
   int          wr_count;
   mem_wr_t     last_wr;

   string       names     [MAX_TESTS];
   logic [31:0] boot_pc   [MAX_TESTS];
   logic [31:0] boot_sp   [MAX_TESTS];
   logic [31:0] prog      [MAX_TESTS][6];
   mem_wr_t     exp_wr    [MAX_TESTS];
   bit          exp_fault [MAX_TESTS];
   int          n_tests    = 0;
   int          pass_count = 0;
   int          fail_count = 0;

   rv_core i_rv_core (
      .clk(clk), .rst(rst),
      .ren(ren), .addr(addr), .rdata(rdata), .rd_valid(rd_valid),
      .wen(wen), .wr(wr), .fault(fault)
   );

   initial begin
      forever #20 clk = ~clk;
   end

   // Reads answer after 0 to 3 idle cycles, writes land by byte mask
   always @(negedge clk) begin
      if (rst) begin
         rd_valid <= 1'b0;
         rnd = $random(seed);
         delay <= rnd[1:0];
      end else begin
         if (wen) begin
            for (int b = 0; b < 4; b++) begin
               if (wr.mask[b]) begin
                  mem[wr.addr[9:2]][8*b +: 8] = wr.data[8*b +: 8];
               end
            end
            last_wr = wr;
            wr_count++;
         end
         if (rd_valid) begin
            rd_valid <= 1'b0;
            rnd = $random(seed);
            delay <= rnd[1:0];
         end else if (ren) begin
            if (delay == 2'd0) begin
               rd_valid <= 1'b1;
               rdata    <= mem[addr[9:2]];
            end else begin
               delay <= delay - 2'd1;
            end
         end
      end
   end

   // RV32I instruction encoders
   function automatic logic [31:0] i_type(input logic [6:0] op, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [4:0] rs1,
                                          input int imm);
      return {imm[11:0], rs1, f3, rd, op};
   endfunction

   function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [4:0] rs2);
      return {f7, rs2, rs1, f3, rd, OP_ALU_R};
   endfunction

   function automatic logic [31:0] s_type(input logic [2:0] f3, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input int imm);
      return {imm[11:5], rs2, rs1, f3, imm[4:0], OP_STORE};
   endfunction

   function automatic logic [31:0] b_type(input logic [2:0] f3, input logic [4:0] rs1,
                                          input logic [4:0] rs2, input int imm);
      return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
   endfunction

   function automatic logic [31:0] u_type(input logic [6:0] op, input logic [4:0] rd,
                                          input logic [19:0] imm);
      return {imm, rd, op};
   endfunction

   function automatic logic [31:0] j_type(input logic [4:0] rd, input int imm);
      return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
   endfunction

   function automatic logic [31:0] addi(input logic [4:0] rd, input logic [4:0] rs1,
                                        input int imm);
      return i_type(OP_ALU_I, 3'h0, rd, rs1, imm);
   endfunction

   function automatic logic [31:0] sw(input logic [4:0] rs2, input logic [4:0] rs1,
                                      input int imm);
      return s_type(3'h2, rs2, rs1, imm);
   endfunction

   task automatic put_row(input string name, input logic [31:0] pc_vec,
                          input logic [31:0] w0, w1, w2, w3, w4, w5,
                          input mem_wr_t wr_exp, input bit flt);
      names[n_tests]     = name;
      boot_pc[n_tests]   = pc_vec;
      boot_sp[n_tests]   = STACK_TOP;
      prog[n_tests][0]   = w0;
      prog[n_tests][1]   = w1;
      prog[n_tests][2]   = w2;
      prog[n_tests][3]   = w3;
      prog[n_tests][4]   = w4;
      prog[n_tests][5]   = w5;
      exp_wr[n_tests]    = wr_exp;
      exp_fault[n_tests] = flt;
      n_tests++;
   endtask

   // x1 = a, x3 = b, then the operation into x5, stored as a word
   task automatic alu_case(input string name, input int a, input int b,
                           input logic [31:0] op_word, input logic [31:0] result);
      mem_wr_t e;
      e.addr = 16'h0300;
      e.data = result;
      e.mask = 4'hf;
      put_row(name, PROG_BASE, addi(1, 0, a), addi(3, 0, b), op_word,
              sw(5, 0, 'h300), 0, 0, e, 1'b0);
   endtask

   // Taken path skips the first store and reaches the second one
   task automatic branch_case(input string name, input logic [2:0] f3,
                              input int a, input int b, input bit taken);
      mem_wr_t e;
      e.addr = taken ? 16'h0344 : 16'h0340;
      e.data = taken ? b : a;
      e.mask = 4'hf;
      put_row(name, PROG_BASE, addi(1, 0, a), addi(3, 0, b), b_type(f3, 1, 3, 12),
              sw(1, 0, 'h340), 0, sw(3, 0, 'h344), e, 1'b0);
   endtask

   task automatic store_case(input string name, input logic [2:0] f3, input int ofs,
                             input logic [31:0] data, input logic [3:0] mask);
      mem_wr_t e;
      e.addr = 16'h0300 + 16'(ofs);
      e.data = data;
      e.mask = mask;
      put_row(name, PROG_BASE, u_type(OP_LUI, 1, 20'h12345), addi(1, 1, 'h678),
              s_type(f3, 1, 0, 'h300 + ofs), 0, 0, 0, e, 1'b0);
   endtask

   // Store x1, load it back into x5, then store x5 as a word
   task automatic load_case(input string name, input logic [31:0] setup,
                            input logic [2:0] st_f3, input logic [2:0] ld_f3,
                            input int ofs, input logic [31:0] result);
      mem_wr_t e;
      e.addr = 16'h0310;
      e.data = result;
      e.mask = 4'hf;
      put_row(name, PROG_BASE, setup, s_type(st_f3, 1, 0, 'h300 + ofs),
              i_type(OP_LOAD, ld_f3, 5, 0, 'h300 + ofs), sw(5, 0, 'h310), 0, 0, e, 1'b0);
   endtask

   task automatic build_table();
      alu_case("alu_addi", -100, 0, addi(5, 1, 45), 32'hffffffc9);
      alu_case("alu_add", -100, 7, r_type(7'h00, 3'h0, 5, 1, 3), 32'hffffffa3);
      alu_case("alu_sub", -100, 7, r_type(7'h20, 3'h0, 5, 3, 1), 32'h0000006b);
      alu_case("alu_sll", 'h123, 7, r_type(7'h00, 3'h1, 5, 1, 3), 32'h00009180);
      alu_case("alu_sra", -100, 2, r_type(7'h20, 3'h5, 5, 1, 3), 32'hffffffe7);
      alu_case("alu_slt", -100, 7, r_type(7'h00, 3'h2, 5, 1, 3), 32'h00000001);
      alu_case("alu_sltu", -100, 7, r_type(7'h00, 3'h3, 5, 1, 3), 32'h00000000);
      alu_case("alu_xor", 'h5a5, 'h0ff, r_type(7'h00, 3'h4, 5, 1, 3), 32'h0000055a);
      alu_case("alu_or", 'h5a5, 'h0ff, r_type(7'h00, 3'h6, 5, 1, 3), 32'h000005ff);
      alu_case("alu_and", 'h5a5, 'h0ff, r_type(7'h00, 3'h7, 5, 1, 3), 32'h000000a5);

      // Starts at 0x104, so the first word is never run
      put_row("boot_vectors", 32'h104, addi(5, 0, 'h111), addi(5, 5, 'h222), sw(5, 2, 8),
              0, 0, 0, {16'h0208, 32'h00000222, 4'hf}, 1'b0);

      store_case("sb_ofs0", 3'h0, 0, 32'h12345678, 4'b0001);
      store_case("sb_ofs1", 3'h0, 1, 32'h34567800, 4'b0010);
      store_case("sb_ofs2", 3'h0, 2, 32'h56780000, 4'b0100);
      store_case("sb_ofs3", 3'h0, 3, 32'h78000000, 4'b1000);
      store_case("sh_ofs0", 3'h1, 0, 32'h12345678, 4'b0011);
      store_case("sh_ofs2", 3'h1, 2, 32'h56780000, 4'b1100);
      store_case("sw_ofs0", 3'h2, 0, 32'h12345678, 4'b1111);

      load_case("lb_0x80", addi(1, 0, 'h80), 3'h0, 3'h0, 1, 32'hffffff80);
      load_case("lbu_0x80", addi(1, 0, 'h80), 3'h0, 3'h4, 1, 32'h00000080);
      load_case("lh_0x8000", u_type(OP_LUI, 1, 20'h8), 3'h1, 3'h1, 2, 32'hffff8000);
      load_case("lhu_0x8000", u_type(OP_LUI, 1, 20'h8), 3'h1, 3'h5, 2, 32'h00008000);
      load_case("lw_word", addi(1, 0, -1234), 3'h2, 3'h2, 0, 32'hfffffb2e);

      branch_case("beq_taken", 3'h0, 5, 5, 1'b1);
      branch_case("beq_not", 3'h0, 5, 6, 1'b0);
      branch_case("bne_taken", 3'h1, 5, 6, 1'b1);
      branch_case("bne_not", 3'h1, 5, 5, 1'b0);
      branch_case("blt_taken", 3'h4, -100, 7, 1'b1);
      branch_case("blt_not", 3'h4, 7, -100, 1'b0);
      branch_case("bge_taken", 3'h5, 7, -100, 1'b1);
      branch_case("bge_not", 3'h5, -100, 7, 1'b0);
      branch_case("bltu_taken", 3'h6, 7, -100, 1'b1);
      branch_case("bltu_not", 3'h6, -100, 7, 1'b0);
      branch_case("bgeu_taken", 3'h7, -100, 7, 1'b1);
      branch_case("bgeu_not", 3'h7, 7, -100, 1'b0);

      put_row("jal_link", PROG_BASE, j_type(5, 8), 0, sw(5, 0, 'h300), 0, 0, 0,
              {16'h0300, 32'h00000104, 4'hf}, 1'b0);
      put_row("jalr_link", PROG_BASE, addi(1, 0, 'h10c), i_type(OP_JALR, 3'h0, 5, 1, 0), 0,
              sw(5, 0, 'h300), 0, 0, {16'h0300, 32'h00000108, 4'hf}, 1'b0);
      put_row("lui", PROG_BASE, u_type(OP_LUI, 5, 20'habcde), sw(5, 0, 'h300), 0, 0, 0, 0,
              {16'h0300, 32'habcde000, 4'hf}, 1'b0);
      put_row("auipc", PROG_BASE, addi(1, 0, 1), u_type(OP_AUIPC, 5, 20'h1), sw(5, 0, 'h300),
              0, 0, 0, {16'h0300, 32'h00001104, 4'hf}, 1'b0);
      put_row("illegal_opcode", PROG_BASE, addi(5, 0, 3), 32'h0000000b, sw(5, 0, 'h300),
              0, 0, 0, '0, 1'b1);
   endtask

   // Fill words have opcode 0, so running past a program faults
   task automatic load_image(input int t);
      for (int i = 0; i < 256; i++) begin
         mem[i] = {8'hee, 8'(i), 16'h0000};
      end
      mem[`RV_VEC_RESET >> 2] = boot_pc[t];
      mem[`RV_VEC_SP >> 2]    = boot_sp[t];
      for (int k = 0; k < 6; k++) begin
         mem[(PROG_BASE >> 2) + k] = prog[t][k];
      end
      wr_count = 0;
      last_wr  = '0;
   endtask

   task automatic check_write(input string name, input mem_wr_t exp, input mem_wr_t act);
      if (act === exp) begin
         pass_count++;
         $display("Pass %s", name);
      end else begin
         fail_count++;
         $display("Fail %s: expected addr %h data %h mask %b, actual addr %h data %h mask %b",
                  name, exp.addr, exp.data, exp.mask, act.addr, act.data, act.mask);
      end
   endtask

   task automatic check_fault(input string name, input bit exp, input bit act);
      if (act === exp) begin
         pass_count++;
         $display("Pass %s", name);
      end else begin
         fail_count++;
         $display("Fail %s: expected fault %b, actual fault %b", name, exp, act);
      end
   endtask

   initial begin
      bit hung;
      bit fault_held;
      int cycles;
      hung = 1'b0;
      build_table();
      for (int t = 0; t < n_tests && !hung; t++) begin
         @(negedge clk);
         rst <= 1'b1;
         load_image(t);
         repeat (10) @(negedge clk);
         rst <= 1'b0;
         cycles = 0;
         // Every program ends on an illegal word, so fault marks its end
         while (fault !== 1'b1 && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
         end
         if (fault !== 1'b1) begin
            $display("Timeout in %s: fault did not rise within %0d cycles", names[t], TIMEOUT);
            fail_count++;
            hung = 1'b1;
         end else if (exp_fault[t]) begin
            // Fault must hold and no store may follow it
            fault_held = 1'b1;
            repeat (FAULT_HOLD) begin
               @(negedge clk);
               if (fault !== 1'b1) begin
                  fault_held = 1'b0;
               end
            end
            if (wr_count != 0) begin
               fail_count++;
               $display("%s: a store was written after the illegal opcode", names[t]);
            end else begin
               check_fault(names[t], exp_fault[t], fault_held);
            end
         end else if (wr_count == 0) begin
            fail_count++;
            $display("%s: the program ended without writing any store", names[t]);
         end else begin
            check_write(names[t], exp_wr[t], last_wr);
         end
      end
      $display("%0d passed, %0d failed", pass_count, fail_count);
      if (fail_count == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: rv_core.f
+incdir+.
rv_isa_pkg.sv
rv_core_pkg.sv
rv_decoder.sv
rv_alu.sv
rv_regfile.sv
rv_lsu.sv
rv_core.sv
tb_rv_core.sv

// File: Bender.yml
package:
  name: rv_core

export_include_dirs:
  - .

sources:
  - rv_isa_pkg.sv
  - rv_core_pkg.sv
  - rv_decoder.sv
  - rv_alu.sv
  - rv_regfile.sv
  - rv_lsu.sv
  - rv_core.sv
  - target: test
    files:
      - tb_rv_core.sv
